/* hdl/isa_pkg.sv */
package isa_pkg;

    // Machine words
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // Coarse instruction classes handed to the back end
    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JUMP,
        CLASS_UPPER,
        CLASS_ILLEGAL
    } op_class_t;

    // Field positions inside a 32-bit word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    // RV32 major opcodes
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    // Widest slot count any stage may be built with
    localparam int MAX_SLOTS = 8;

    // Per-slot valid or accept bits, each stage uses its low bits
    typedef logic [MAX_SLOTS-1:0] slot_mask_t;

    // Fixed-length encoding, no compressed words
    localparam int INSTR_BYTES = 4;

    // Byte offset bits below the word index
    localparam int INSTR_SHIFT = $clog2(INSTR_BYTES);

endpackage

/* hdl/fetch_if.sv */
`timescale 1ns/1ns

interface fetch_if
    import isa_pkg::*;
#(
    parameter int IF_WIDTH = 2
);

    // One fetch packet, slot 0 is the lowest address
    logic   [IF_WIDTH-1:0] valid;
    pc_t    [IF_WIDTH-1:0] pc;
    instr_t [IF_WIDTH-1:0] instr;

    // Buffer has no room for a whole packet
    logic                  stall;

    modport fetch (output valid, output pc, output instr, input stall);
    modport buffer (input valid, input pc, input instr, output stall);

endinterface

/* hdl/issue_if.sv */
`timescale 1ns/1ns

interface issue_if
    import isa_pkg::*;
#(
    parameter int ID_WIDTH = 2
);

    // Head of the queue, slot 0 is the oldest entry
    logic   [ID_WIDTH-1:0] valid;
    pc_t    [ID_WIDTH-1:0] pc;
    instr_t [ID_WIDTH-1:0] instr;

    // Prefix of valid, entries leave at the next edge
    logic   [ID_WIDTH-1:0] accept;

    modport buffer (output valid, output pc, output instr, input accept);
    modport decode (input valid, input pc, input instr, output accept);

endinterface

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int  IF_WIDTH = 2,
    parameter pc_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  redirect_i,
    input  pc_t                   redirect_pc_i,
    output pc_t                   imem_addr_o,
    input  instr_t [IF_WIDTH-1:0] imem_rdata_i,
    fetch_if.fetch                f
);

    localparam int  PKT_BYTES = IF_WIDTH * INSTR_BYTES;
    localparam int  OFF_W     = (IF_WIDTH > 1) ? $clog2(IF_WIDTH) : 1;
    localparam pc_t PKT_MASK  = ~pc_t'(PKT_BYTES - 1);
    localparam pc_t SLOT_MASK = pc_t'(IF_WIDTH - 1);

    // Word offset of the reset address within its packet
    localparam logic [OFF_W-1:0] RESET_SLOT = OFF_W'((RESET_PC >> INSTR_SHIFT) & SLOT_MASK);

    pc_t              pc_q;
    logic [OFF_W-1:0] first_slot_q;
    logic             run_q;
    logic [OFF_W-1:0] redir_slot_w;
    logic             fetch_go_w;
    slot_mask_t       slot_valid_w;

    assign redir_slot_w = OFF_W'((redirect_pc_i >> INSTR_SHIFT) & SLOT_MASK);

    // Packet goes out only when the buffer can take all of it
    assign fetch_go_w  = run_q && !f.stall && !redirect_i;
    assign imem_addr_o = pc_q;

    always_comb begin
        slot_valid_w = '0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            // Words before a misaligned target are skipped
            slot_valid_w[i] = fetch_go_w && (i >= int'(first_slot_q));
        end
    end

    assign f.valid = slot_valid_w[IF_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            f.pc[i]    = pc_q + pc_t'(i * INSTR_BYTES);
            f.instr[i] = imem_rdata_i[i];
        end
    end

    // pc_q always holds a packet base address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q         <= RESET_PC & PKT_MASK;
            first_slot_q <= RESET_SLOT;
            run_q        <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                pc_q         <= redirect_pc_i & PKT_MASK;
                first_slot_q <= redir_slot_w;
            end else if (fetch_go_w) begin
                pc_q         <= pc_q + pc_t'(PKT_BYTES);
                first_slot_q <= '0;
            end
        end
    end

endmodule

/* hdl/instr_buffer.sv */
`timescale 1ns/1ns

module instr_buffer
    import isa_pkg::*;
#(
    parameter int IF_WIDTH  = 2,
    parameter int ID_WIDTH  = 2,
    parameter int BUF_DEPTH = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush_i,
    fetch_if.buffer f,
    issue_if.buffer q
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Entry storage, pc and word side by side
    pc_t    pc_mem    [BUF_DEPTH];
    instr_t instr_mem [BUF_DEPTH];

    ptr_t rd_ptr_q;
    ptr_t wr_ptr_q;
    cnt_t count_q;
    cnt_t free_w;
    cnt_t wr_num_w;
    cnt_t pop_num_w;
    ptr_t wr_addr_w [IF_WIDTH];

    // Compaction: each valid slot lands after the valid slots below it
    always_comb begin
        wr_num_w = '0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            wr_addr_w[i] = wr_ptr_q + ptr_t'(wr_num_w);
            wr_num_w     = wr_num_w + cnt_t'(f.valid[i]);
        end
    end

    // Accept is a prefix, so its popcount is the pop amount
    always_comb begin
        pop_num_w = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            pop_num_w = pop_num_w + cnt_t'(q.accept[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            if (f.valid[i]) begin
                pc_mem[wr_addr_w[i]]    <= f.pc[i];
                instr_mem[wr_addr_w[i]] <= f.instr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + ptr_t'(pop_num_w);
            wr_ptr_q <= wr_ptr_q + ptr_t'(wr_num_w);
            count_q  <= count_q + wr_num_w - pop_num_w;
        end
    end

    // Head slots, oldest first
    always_comb begin
        ptr_t rd_addr;
        for (int i = 0; i < ID_WIDTH; i++) begin
            rd_addr    = rd_ptr_q + ptr_t'(i);
            q.valid[i] = count_q > cnt_t'(i);
            q.pc[i]    = pc_mem[rd_addr];
            q.instr[i] = instr_mem[rd_addr];
        end
    end

    // Stall once a full packet might not fit
    assign free_w  = cnt_t'(BUF_DEPTH) - count_q;
    assign f.stall = free_w < cnt_t'(IF_WIDTH);

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int ID_WIDTH = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  logic [ID_WIDTH-1:0]      issue_ready_i,
    issue_if.decode                  q,
    output logic [ID_WIDTH-1:0]      dec_valid_o,
    output pc_t [ID_WIDTH-1:0]       dec_pc_o,
    output op_class_t [ID_WIDTH-1:0] dec_class_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rd_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rs1_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rs2_o
);

    slot_mask_t accept_w;

    // Class from the major opcode only
    function automatic op_class_t classify(input instr_t instr);
        opcode_t opc;
        opc = instr[OPCODE_LSB +: $bits(opcode_t)];
        case (opc)
            OPC_OP, OPC_OP_IMM: return CLASS_ALU;
            OPC_LOAD:           return CLASS_LOAD;
            OPC_STORE:          return CLASS_STORE;
            OPC_BRANCH:         return CLASS_BRANCH;
            OPC_JAL, OPC_JALR:  return CLASS_JUMP;
            OPC_LUI, OPC_AUIPC: return CLASS_UPPER;
            default:            return CLASS_ILLEGAL;
        endcase
    endfunction

    // In-order prefix, first gap stops the rest
    always_comb begin
        logic take;
        take     = !flush_i;
        accept_w = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            take        = take && q.valid[i] && issue_ready_i[i];
            accept_w[i] = take;
        end
    end

    assign q.accept = accept_w[ID_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_o <= '0;
        end else begin
            dec_valid_o <= accept_w[ID_WIDTH-1:0];
        end
    end

    // Payload only moves on accept, valid qualifies it
    always_ff @(posedge clk) begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (accept_w[i]) begin
                dec_pc_o[i]    <= q.pc[i];
                dec_class_o[i] <= classify(q.instr[i]);
                dec_rd_o[i]    <= q.instr[i][RD_LSB +: $bits(reg_idx_t)];
                dec_rs1_o[i]   <= q.instr[i][RS1_LSB +: $bits(reg_idx_t)];
                dec_rs2_o[i]   <= q.instr[i][RS2_LSB +: $bits(reg_idx_t)];
            end
        end
    end

endmodule

/* hdl/frontend_top.sv */
`timescale 1ns/1ns

module frontend_top
    import isa_pkg::*;
#(
    parameter int  IF_WIDTH  = 2,
    parameter int  ID_WIDTH  = 2,
    parameter int  BUF_DEPTH = 16,
    parameter pc_t RESET_PC  = 32'h0000_0000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output pc_t                      imem_addr_o,
    input  instr_t [IF_WIDTH-1:0]    imem_rdata_i,
    input  logic [ID_WIDTH-1:0]      issue_ready_i,
    input  logic                     redirect_i,
    input  pc_t                      redirect_pc_i,
    output logic [ID_WIDTH-1:0]      dec_valid_o,
    output pc_t [ID_WIDTH-1:0]       dec_pc_o,
    output op_class_t [ID_WIDTH-1:0] dec_class_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rd_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rs1_o,
    output reg_idx_t [ID_WIDTH-1:0]  dec_rs2_o
);

    fetch_if #(.IF_WIDTH(IF_WIDTH)) fetch_bus ();
    issue_if #(.ID_WIDTH(ID_WIDTH)) issue_bus ();

    fetch_unit #(
        .IF_WIDTH (IF_WIDTH),
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .f             (fetch_bus.fetch)
    );

    // Redirect doubles as flush for everything past fetch
    instr_buffer #(
        .IF_WIDTH  (IF_WIDTH),
        .ID_WIDTH  (ID_WIDTH),
        .BUF_DEPTH (BUF_DEPTH)
    ) i_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (redirect_i),
        .f       (fetch_bus.buffer),
        .q       (issue_bus.buffer)
    );

    decode_stage #(
        .ID_WIDTH (ID_WIDTH)
    ) i_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_i),
        .issue_ready_i (issue_ready_i),
        .q             (issue_bus.decode),
        .dec_valid_o   (dec_valid_o),
        .dec_pc_o      (dec_pc_o),
        .dec_class_o   (dec_class_o),
        .dec_rd_o      (dec_rd_o),
        .dec_rs1_o     (dec_rs1_o),
        .dec_rs2_o     (dec_rs2_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Free running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

/* tb/frontend_checker.sv */
`timescale 1ns/1ns

module frontend_checker #(
    parameter int IF_WIDTH  = 2,
    parameter int ID_WIDTH  = 2,
    parameter int BUF_DEPTH = 16
) (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       flush_i,
    input logic [$clog2(BUF_DEPTH):0] count_i,
    input logic                       stall_i,
    input logic [IF_WIDTH-1:0]        fetch_valid_i,
    input logic [ID_WIDTH-1:0]        head_valid_i,
    input logic [ID_WIDTH-1:0]        accept_i
);

    typedef logic [$clog2(BUF_DEPTH):0] cnt_t;
    typedef logic [ID_WIDTH-1:0]        acc_t;

    // Running count of failed assertions
    int fail_count = 0;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        count_i <= cnt_t'(BUF_DEPTH))
        else begin
            fail_count++;
            $error("buffer occupancy %0d above depth", count_i);
        end

    // Fetch must hold while the buffer asks for a stall
    a_stall_holds_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> (fetch_valid_i == '0))
        else begin
            fail_count++;
            $error("fetch slot valid during stall");
        end

    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> (count_i == '0))
        else begin
            fail_count++;
            $error("buffer not empty after flush");
        end

    // Accepted slots are valid and contiguous from slot 0
    a_accept_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        ((accept_i & ~head_valid_i) == '0) && ((accept_i & (accept_i + acc_t'(1))) == '0))
        else begin
            fail_count++;
            $error("accept bits %b not a prefix of valid %b", accept_i, head_valid_i);
        end

endmodule

bind instr_buffer frontend_checker #(
    .IF_WIDTH  (IF_WIDTH),
    .ID_WIDTH  (ID_WIDTH),
    .BUF_DEPTH (BUF_DEPTH)
) i_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .count_i       (count_q),
    .stall_i       (f.stall),
    .fetch_valid_i (f.valid),
    .head_valid_i  (q.valid),
    .accept_i      (q.accept)
);

/* tb/tb_frontend.sv */
`timescale 1ns/1ns

module tb_frontend
    import isa_pkg::*;
();

    localparam int  IF_WIDTH    = 2;
    localparam int  ID_WIDTH    = 2;
    localparam pc_t RESET_PC    = 32'h0000_0000;
    localparam int  PERIOD      = 4;
    localparam int  MEM_AW      = 8;
    localparam int  MEM_WORDS   = 1 << MEM_AW;
    localparam int  STREAM_CYC  = 200;
    localparam int  BACKPR_CYC  = 400;
    localparam int  REDIR_CYC   = 400;
    localparam int  TOTAL_CYC   = 3 + STREAM_CYC + BACKPR_CYC + REDIR_CYC;
    localparam int  WATCHDOG_NS = (TOTAL_CYC + 100) * PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'd86747;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef logic [MEM_AW-1:0] mem_idx_t;

    logic                     clk;
    logic                     rst_n;
    pc_t                      imem_addr;
    instr_t [IF_WIDTH-1:0]    imem_rdata;
    logic [ID_WIDTH-1:0]      issue_ready;
    logic                     redirect;
    pc_t                      redirect_pc;
    logic [ID_WIDTH-1:0]      dec_valid;
    pc_t [ID_WIDTH-1:0]       dec_pc;
    op_class_t [ID_WIDTH-1:0] dec_class;
    reg_idx_t [ID_WIDTH-1:0]  dec_rd;
    reg_idx_t [ID_WIDTH-1:0]  dec_rs1;
    reg_idx_t [ID_WIDTH-1:0]  dec_rs2;

    instr_t      mem [MEM_WORDS];
    logic [31:0] lfsr_q = LFSR_SEED;
    pc_t         exp_pc;
    int          errors = 0;
    int          decoded = 0;
    int          tests = 0;
    int          assert_seen = 0;

    tb_clock_gen #(.PERIOD_NS(PERIOD)) i_clk (.clk_o(clk));

    frontend_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr_o   (imem_addr),
        .imem_rdata_i  (imem_rdata),
        .issue_ready_i (issue_ready),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .dec_valid_o   (dec_valid),
        .dec_pc_o      (dec_pc),
        .dec_class_o   (dec_class),
        .dec_rd_o      (dec_rd),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2)
    );

    // Instruction memory without latency that wraps at its size
    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            imem_rdata[i] = mem[mem_idx_t'(imem_addr >> 2) + mem_idx_t'(i)];
        end
    end

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    // RISC-V major opcodes
    function automatic op_class_t model_class(input instr_t w);
        case (w[6:0])
            7'h33, 7'h13: return CLASS_ALU;
            7'h03:        return CLASS_LOAD;
            7'h23:        return CLASS_STORE;
            7'h63:        return CLASS_BRANCH;
            7'h6f, 7'h67: return CLASS_JUMP;
            7'h37, 7'h17: return CLASS_UPPER;
            default:      return CLASS_ILLEGAL;
        endcase
    endfunction

    task automatic cmp_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic cmp_class(input op_class_t got, input op_class_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %s, expected %s", $time, what, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic cmp_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic cmp_valid(input logic [ID_WIDTH-1:0] got, input logic [ID_WIDTH-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Valid slots in slot order against the sequential model PC
    task automatic check_outputs();
        instr_t w;
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (dec_valid[i]) begin
                w = mem[mem_idx_t'(exp_pc >> 2)];
                cmp_pc(dec_pc[i], exp_pc, $sformatf("slot %0d pc", i));
                cmp_class(dec_class[i], model_class(w), $sformatf("slot %0d class", i));
                cmp_reg(dec_rd[i], w[11:7], $sformatf("slot %0d rd", i));
                cmp_reg(dec_rs1[i], w[19:15], $sformatf("slot %0d rs1", i));
                cmp_reg(dec_rs2[i], w[24:20], $sformatf("slot %0d rs2", i));
                exp_pc = exp_pc + 4;
                decoded++;
            end
        end
    endtask

    task automatic drive_inputs(input bit rand_ready, input bit use_redirect);
        logic [31:0] bits;
        bits = rand_bits(ID_WIDTH);
        issue_ready = rand_ready ? bits[ID_WIDTH-1:0] : '1;
        bits = rand_bits(4);
        redirect = use_redirect && (bits[3:0] == 4'd0);
        if (redirect) begin
            redirect_pc = pc_t'(rand_bits(MEM_AW)) << 2;
            // Model restarts at the target taken at the next edge
            exp_pc = redirect_pc;
        end
    endtask

    // Bound assertion failures count against the test that saw them
    task automatic collect_assertions();
        int now_fails;
        now_fails = i_dut.i_buffer.i_checker.fail_count;
        errors += now_fails - assert_seen;
        assert_seen = now_fails;
    endtask

    task automatic report_test(input string name, input int errs_before, input int seen);
        collect_assertions();
        tests++;
        $display("test %s: %0d instructions, %0d errors", name, seen, errors - errs_before);
    endtask

    task automatic run_phase(input string name, input int cycles, input bit rand_ready,
                             input bit use_redirect);
        int errs_before;
        int seen_before;
        errs_before = errors;
        seen_before = decoded;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_outputs();
            drive_inputs(rand_ready, use_redirect);
        end
        if (decoded == seen_before) begin
            $display("Test %s decoded no instructions at all", name);
            errors++;
        end
        report_test(name, errs_before, decoded - seen_before);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] word;
        int errs_before;
        rst_n = 1'b0;
        issue_ready = '0;
        redirect = 1'b0;
        redirect_pc = '0;
        exp_pc = RESET_PC;
        // Random words with the low opcode bits forced to 11 so real classes show up
        for (int a = 0; a < MEM_WORDS; a++) begin
            word = rand_bits(30);
            mem[mem_idx_t'(a)] = {word[29:0], 2'b11};
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        issue_ready = '1;
        errs_before = errors;
        cmp_valid(dec_valid, '0, "dec_valid after reset");
        cmp_pc(imem_addr, RESET_PC, "imem_addr after reset");
        report_test("reset", errs_before, 0);
        run_phase("stream", STREAM_CYC, 1'b0, 1'b0);
        run_phase("backpressure", BACKPR_CYC, 1'b1, 1'b0);
        run_phase("redirect", REDIR_CYC, 1'b1, 1'b1);
        $display("%0d tests, %0d instructions checked, %0d errors", tests, decoded, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_if.sv
hdl/issue_if.sv
hdl/fetch_unit.sv
hdl/instr_buffer.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
tb/tb_clock_gen.sv
tb/frontend_checker.sv
tb/tb_frontend.sv

/* Makefile */
# Verilator build and run for the instruction front end

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is ignored, the log decides
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
